// File: include/llc_defines.svh
`ifndef LLC_DEFINES_SVH
`define LLC_DEFINES_SVH

// Entries per input FIFO
`define LLC_FIFO_DEPTH 4

// Message field widths
`define LLC_ADDR_W 32
`define LLC_DATA_W 32

`endif

// File: src/llc_pkg.sv
`include "llc_defines.svh"

package llc_pkg;

    typedef struct packed {
        logic flush;                       // Flush instead of plain reset
    } llc_rst_t;

    typedef struct packed {
        logic [`LLC_ADDR_W-1:0] addr;
        logic [`LLC_DATA_W-1:0] data;
    } llc_rsp_t;

    typedef struct packed {
        logic [1:0]             op;
        logic [`LLC_ADDR_W-1:0] addr;
        logic [`LLC_DATA_W-1:0] data;
    } llc_req_t;

    typedef struct packed {
        logic                   write;
        logic [`LLC_ADDR_W-1:0] addr;
        logic [`LLC_DATA_W-1:0] data;
    } llc_dma_req_t;

    typedef struct packed {
        logic recall_pending;
        logic recall_valid;
        logic rst_stall;
        logic flush_stall;
        logic req_stall;
        logic dma_read_pending;
        logic dma_write_pending;
        logic save_req;                    // Strobe, keep last dispatched request
    } llc_status_t;

    typedef enum logic [3:0] {
        kind_rst,
        kind_rsp,
        kind_req,
        kind_stalled_req,
        kind_dma_req,
        kind_rst_resume,
        kind_flush_resume,
        kind_dma_read_resume,
        kind_dma_write_resume
    } llc_kind_t;

    typedef struct packed {
        logic rst_to_resume;
        logic flush_to_resume;
        logic rst_to_get;
        logic rsp_to_get;
        logic req_to_get;
        logic dma_req_to_get;
    } llc_sel_t;

    typedef struct packed {
        llc_kind_t              kind;
        logic                   look;      // Needs a cache lookup
        logic [1:0]             op;
        logic [`LLC_ADDR_W-1:0] addr;
        logic [`LLC_DATA_W-1:0] data;
    } llc_dispatch_t;

endpackage

// File: src/llc_in_fifo.sv
`timescale 1ns/1ps
`include "llc_defines.svh"

module llc_in_fifo #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_req,
    input  payload_t in_data,
    output logic     in_ack,
    input  logic     pop,
    output logic     valid,
    output payload_t head
);

    localparam int ptr_w = $clog2(`LLC_FIFO_DEPTH);

    payload_t         mem [`LLC_FIFO_DEPTH];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w:0]   count;
    logic             push;
    logic             pop_ok;

    // New word only once the previous ack has dropped
    assign push   = in_req && !in_ack && (count < `LLC_FIFO_DEPTH);
    assign pop_ok = pop && valid;
    assign valid  = (count != '0);
    assign head   = mem[rd_ptr];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            in_ack <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_w'(`LLC_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
                in_ack <= 1'b1;
            end else if (in_ack && !in_req) begin
                in_ack <= 1'b0;                // Producer released, close handshake
            end
            if (pop_ok) begin
                rd_ptr <= (rd_ptr == ptr_w'(`LLC_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

endmodule

// File: src/llc_input_decoder.sv
`timescale 1ns/1ps

module llc_input_decoder (
    input  logic                clk,
    input  logic                rst,
    input  logic                decode_en,
    input  llc_pkg::llc_status_t status,
    input  logic                rst_valid,
    input  logic                rsp_valid,
    input  logic                req_valid,
    input  logic                dma_valid,
    input  logic                req_in_stalled_valid,
    input  logic                is_dma_read_to_resume,
    input  logic                is_dma_write_to_resume,
    output llc_pkg::llc_sel_t   sel,
    output logic                look,
    output logic                do_get_req,
    output logic                do_get_dma_req,
    output logic                update_req_in_from_stalled,
    output logic                clr_req_in_stalled_valid,
    output logic                set_dma_read_resume,
    output logic                set_dma_write_resume,
    output logic                clr_dma_read_resume,
    output logic                clr_dma_write_resume
);

    llc_pkg::llc_sel_t sel_next;
    logic              dma_pending;

    assign dma_pending = status.dma_read_pending | status.dma_write_pending;

    always_comb begin
        sel_next                   = '0;
        do_get_req                 = 1'b0;
        do_get_dma_req             = 1'b0;
        update_req_in_from_stalled = 1'b0;
        clr_req_in_stalled_valid   = 1'b0;
        set_dma_read_resume        = 1'b0;
        set_dma_write_resume       = 1'b0;
        clr_dma_read_resume        = 1'b0;
        clr_dma_write_resume       = 1'b0;
        if (decode_en) begin
            clr_dma_read_resume  = 1'b1;       // Flags live for one decode only
            clr_dma_write_resume = 1'b1;
            if (status.recall_pending) begin
                if (!status.recall_valid) begin
                    sel_next.rsp_to_get = rsp_valid;
                end else if (status.dma_read_pending) begin
                    set_dma_read_resume = 1'b1;
                    clr_dma_read_resume = 1'b0;
                end else if (status.dma_write_pending) begin
                    set_dma_write_resume = 1'b1;
                    clr_dma_write_resume = 1'b0;
                end
            end else if (status.rst_stall) begin
                sel_next.rst_to_resume = 1'b1;
            end else if (status.flush_stall) begin
                sel_next.flush_to_resume = 1'b1;
            end else if (rst_valid && !dma_pending) begin
                sel_next.rst_to_get = 1'b1;
            end else if (rsp_valid) begin
                sel_next.rsp_to_get = 1'b1;
            end else if (!status.req_stall && (req_valid || req_in_stalled_valid)) begin
                if (req_in_stalled_valid) begin // Replay beats the FIFO
                    update_req_in_from_stalled = 1'b1;
                    clr_req_in_stalled_valid   = 1'b1;
                end else begin
                    do_get_req = 1'b1;
                end
                sel_next.req_to_get = 1'b1;
            end else if (status.dma_read_pending) begin
                set_dma_read_resume = 1'b1;
                clr_dma_read_resume = 1'b0;
            end else if (status.dma_write_pending) begin
                if (dma_valid) begin
                    set_dma_write_resume = 1'b1;
                    clr_dma_write_resume = 1'b0;
                    do_get_dma_req       = 1'b1;
                end
            end else if (dma_valid && !status.req_stall) begin
                sel_next.dma_req_to_get = 1'b1;
                do_get_dma_req          = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            sel <= '0;
        end else if (decode_en) begin
            sel <= sel_next;
        end
    end

    // Resume lookups wait until the recall is gone
    assign look = sel.flush_to_resume | sel.rsp_to_get | sel.req_to_get
                | sel.dma_req_to_get
                | (is_dma_read_to_resume & ~status.recall_pending)
                | (is_dma_write_to_resume & ~status.recall_pending);

endmodule

// File: src/llc_resume_regs.sv
`timescale 1ns/1ps

module llc_resume_regs (
    input  logic              clk,
    input  logic              rst,
    input  logic              save_req,
    input  llc_pkg::llc_req_t last_req,
    input  logic              clr_req_in_stalled_valid,
    input  logic              set_dma_read_resume,
    input  logic              set_dma_write_resume,
    input  logic              clr_dma_read_resume,
    input  logic              clr_dma_write_resume,
    output logic              req_in_stalled_valid,
    output llc_pkg::llc_req_t req_in_stalled,
    output logic              is_dma_read_to_resume,
    output logic              is_dma_write_to_resume
);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            req_in_stalled_valid   <= 1'b0;
            is_dma_read_to_resume  <= 1'b0;
            is_dma_write_to_resume <= 1'b0;
        end else begin
            if (save_req) begin
                req_in_stalled_valid <= 1'b1;
            end else if (clr_req_in_stalled_valid) begin
                req_in_stalled_valid <= 1'b0;
            end
            if (set_dma_read_resume) begin
                is_dma_read_to_resume <= 1'b1; // Set wins over clear
            end else if (clr_dma_read_resume) begin
                is_dma_read_to_resume <= 1'b0;
            end
            if (set_dma_write_resume) begin
                is_dma_write_to_resume <= 1'b1;
            end else if (clr_dma_write_resume) begin
                is_dma_write_to_resume <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (save_req) begin
            req_in_stalled <= last_req;
        end
    end

endmodule

// File: src/llc_dispatch.sv
`timescale 1ns/1ps

module llc_dispatch (
    input  logic                   clk,
    input  logic                   rst,
    input  llc_pkg::llc_sel_t      sel,
    input  logic                   look,
    input  logic                   do_get_req,
    input  logic                   do_get_dma_req,
    input  logic                   update_req_in_from_stalled,
    input  logic                   set_dma_read_resume,
    input  logic                   set_dma_write_resume,
    input  llc_pkg::llc_rst_t      rst_head,
    input  llc_pkg::llc_rsp_t      rsp_head,
    input  llc_pkg::llc_req_t      req_head,
    input  llc_pkg::llc_req_t      req_in_stalled,
    input  llc_pkg::llc_dma_req_t  dma_head,
    output logic                   decode_en,
    output logic                   pop_rst,
    output logic                   pop_rsp,
    output llc_pkg::llc_req_t      last_req,
    output logic                   out_req,
    input  logic                   out_ack,
    output llc_pkg::llc_dispatch_t out_rec
);

    typedef enum logic [1:0] {st_idle, st_decode, st_build, st_handshake} state_t;

    state_t                 state;
    llc_pkg::llc_dispatch_t cap;           // Payload and kind hint taken in decode
    llc_pkg::llc_dispatch_t rec;
    logic                   cap_rd;
    logic                   cap_wr;
    logic                   rec_due;

    assign decode_en = (state == st_decode);
    assign pop_rst   = (state == st_build) && sel.rst_to_get;
    assign pop_rsp   = (state == st_build) && sel.rsp_to_get;

    // Read resume only counts once look confirms the recall is over
    assign rec_due = (|sel) | cap_wr | (cap_rd & look);

    always_comb begin
        rec      = cap;
        rec.look = look;
        if (sel.rst_to_get) begin
            rec.kind    = llc_pkg::kind_rst;
            rec.op      = '0;
            rec.addr    = '0;
            rec.data    = '0;
            rec.data[0] = rst_head.flush;
        end else if (sel.rsp_to_get) begin
            rec.kind = llc_pkg::kind_rsp;
            rec.op   = '0;
            rec.addr = rsp_head.addr;
            rec.data = rsp_head.data;
        end else if (sel.rst_to_resume || sel.flush_to_resume) begin
            rec.kind = sel.rst_to_resume ? llc_pkg::kind_rst_resume
                                         : llc_pkg::kind_flush_resume;
            rec.op   = '0;
            rec.addr = '0;
            rec.data = '0;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state   <= st_idle;
            out_req <= 1'b0;
            cap_rd  <= 1'b0;
            cap_wr  <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (!out_ack) state <= st_decode;
                end
                st_decode: begin
                    cap_rd <= set_dma_read_resume;
                    cap_wr <= set_dma_write_resume & do_get_dma_req;
                    state  <= st_build;
                end
                st_build: begin
                    if (rec_due) begin
                        out_req <= 1'b1;
                        state   <= st_handshake;
                    end else begin
                        state <= st_decode; // Nothing to send, decode again
                    end
                end
                default: begin
                    if (out_ack) begin
                        out_req <= 1'b0;
                        state   <= st_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_decode) begin
            cap      <= '0;
            cap.kind <= llc_pkg::kind_dma_read_resume;
            if (update_req_in_from_stalled) begin
                cap.kind <= llc_pkg::kind_stalled_req;
                cap.op   <= req_in_stalled.op;
                cap.addr <= req_in_stalled.addr;
                cap.data <= req_in_stalled.data;
            end else if (do_get_req) begin
                cap.kind <= llc_pkg::kind_req;
                cap.op   <= req_head.op;
                cap.addr <= req_head.addr;
                cap.data <= req_head.data;
            end else if (do_get_dma_req) begin
                cap.kind <= set_dma_write_resume ? llc_pkg::kind_dma_write_resume
                                                 : llc_pkg::kind_dma_req;
                cap.op   <= {1'b0, dma_head.write};
                cap.addr <= dma_head.addr;
                cap.data <= dma_head.data;
            end
        end
        if (state == st_build && rec_due) begin
            out_rec <= rec;
            if (sel.req_to_get) begin
                last_req <= '{op: cap.op, addr: cap.addr, data: cap.data};
            end
        end
    end

endmodule

// File: src/llc_front.sv
`timescale 1ns/1ps

module llc_front (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rst_in_req,
    input  llc_pkg::llc_rst_t      rst_in_data,
    output logic                   rst_in_ack,
    input  logic                   rsp_in_req,
    input  llc_pkg::llc_rsp_t      rsp_in_data,
    output logic                   rsp_in_ack,
    input  logic                   req_in_req,
    input  llc_pkg::llc_req_t      req_in_data,
    output logic                   req_in_ack,
    input  logic                   dma_in_req,
    input  llc_pkg::llc_dma_req_t  dma_in_data,
    output logic                   dma_in_ack,
    input  llc_pkg::llc_status_t   status,
    output logic                   out_req,
    input  logic                   out_ack,
    output llc_pkg::llc_dispatch_t out_rec
);

    llc_pkg::llc_rst_t     rst_head;
    llc_pkg::llc_rsp_t     rsp_head;
    llc_pkg::llc_req_t     req_head;
    llc_pkg::llc_dma_req_t dma_head;
    llc_pkg::llc_req_t     req_in_stalled;
    llc_pkg::llc_req_t     last_req;
    llc_pkg::llc_sel_t     sel;
    logic rst_valid;
    logic rsp_valid;
    logic req_valid;
    logic dma_valid;
    logic pop_rst;
    logic pop_rsp;
    logic decode_en;
    logic look;
    logic do_get_req;
    logic do_get_dma_req;
    logic update_req_in_from_stalled;
    logic clr_req_in_stalled_valid;
    logic req_in_stalled_valid;
    logic set_dma_read_resume;
    logic set_dma_write_resume;
    logic clr_dma_read_resume;
    logic clr_dma_write_resume;
    logic is_dma_read_to_resume;
    logic is_dma_write_to_resume;

    llc_in_fifo #(.payload_t(llc_pkg::llc_rst_t)) u_rst_fifo (
        .clk, .rst, .in_req(rst_in_req), .in_data(rst_in_data), .in_ack(rst_in_ack),
        .pop(pop_rst), .valid(rst_valid), .head(rst_head)
    );

    llc_in_fifo #(.payload_t(llc_pkg::llc_rsp_t)) u_rsp_fifo (
        .clk, .rst, .in_req(rsp_in_req), .in_data(rsp_in_data), .in_ack(rsp_in_ack),
        .pop(pop_rsp), .valid(rsp_valid), .head(rsp_head)
    );

    llc_in_fifo #(.payload_t(llc_pkg::llc_req_t)) u_req_fifo (
        .clk, .rst, .in_req(req_in_req), .in_data(req_in_data), .in_ack(req_in_ack),
        .pop(do_get_req), .valid(req_valid), .head(req_head)
    );

    llc_in_fifo #(.payload_t(llc_pkg::llc_dma_req_t)) u_dma_fifo (
        .clk, .rst, .in_req(dma_in_req), .in_data(dma_in_data), .in_ack(dma_in_ack),
        .pop(do_get_dma_req), .valid(dma_valid), .head(dma_head)
    );

    llc_input_decoder u_decoder (
        .clk, .rst, .decode_en, .status, .rst_valid, .rsp_valid, .req_valid, .dma_valid,
        .req_in_stalled_valid, .is_dma_read_to_resume, .is_dma_write_to_resume, .sel,
        .look, .do_get_req, .do_get_dma_req, .update_req_in_from_stalled,
        .clr_req_in_stalled_valid, .set_dma_read_resume, .set_dma_write_resume,
        .clr_dma_read_resume, .clr_dma_write_resume
    );

    llc_resume_regs u_resume (
        .clk, .rst, .save_req(status.save_req), .last_req, .clr_req_in_stalled_valid,
        .set_dma_read_resume, .set_dma_write_resume, .clr_dma_read_resume,
        .clr_dma_write_resume, .req_in_stalled_valid, .req_in_stalled,
        .is_dma_read_to_resume, .is_dma_write_to_resume
    );

    llc_dispatch u_dispatch (
        .clk, .rst, .sel, .look, .do_get_req, .do_get_dma_req, .update_req_in_from_stalled,
        .set_dma_read_resume, .set_dma_write_resume, .rst_head, .rsp_head, .req_head,
        .req_in_stalled, .dma_head, .decode_en, .pop_rst, .pop_rsp, .last_req, .out_req,
        .out_ack, .out_rec
    );

endmodule

// File: verif/llc_front_tb.sv
`timescale 1ns/1ps
`include "llc_defines.svh"

module llc_front_tb;

    localparam int n_msgs      = 42;
    localparam int cycle_limit = 40 * n_msgs + 2000;

    // Status bits from the msb are recall_pending, recall_valid, rst_stall, flush_stall,
    // req_stall, dma_read_pending, dma_write_pending and save_req
    localparam llc_pkg::llc_status_t st_idle = 8'h00;
    localparam llc_pkg::llc_status_t st_park = 8'hc0; // Valid recall with no DMA keeps decoder idle

    logic                   clk;
    logic                   rst;
    logic                   rst_in_req;
    llc_pkg::llc_rst_t      rst_in_data;
    logic                   rst_in_ack;
    logic                   rsp_in_req;
    llc_pkg::llc_rsp_t      rsp_in_data;
    logic                   rsp_in_ack;
    logic                   req_in_req;
    llc_pkg::llc_req_t      req_in_data;
    logic                   req_in_ack;
    logic                   dma_in_req;
    llc_pkg::llc_dma_req_t  dma_in_data;
    logic                   dma_in_ack;
    llc_pkg::llc_status_t   status;
    logic                   out_req;
    logic                   out_ack;
    llc_pkg::llc_dispatch_t out_rec;

    llc_pkg::llc_dispatch_t exp_rec;
    llc_pkg::llc_req_t      last_req;
    llc_pkg::llc_req_t      stalled;
    logic [65:0]            rst_q[$];
    logic [65:0]            rsp_q[$];
    logic [65:0]            req_q[$];
    logic [65:0]            dma_q[$];
    logic                   stalled_valid;
    logic                   out_req_seen;
    logic                   due;
    logic [31:0]            rnd;
    int                     errors;
    int                     checks;
    int                     budget;
    int                     cycles;

    llc_front dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic report(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    assert property (@(posedge clk) disable iff (!rst) rst_in_ack |-> $past(rst_in_req))
        else report("Reset command port acked without a request");
    assert property (@(posedge clk) disable iff (!rst) rsp_in_ack |-> $past(rsp_in_req))
        else report("Response port acked without a request");
    assert property (@(posedge clk) disable iff (!rst) req_in_ack |-> $past(req_in_req))
        else report("Request port acked without a request");
    assert property (@(posedge clk) disable iff (!rst) dma_in_ack |-> $past(dma_in_req))
        else report("DMA port acked without a request");
    assert property (@(posedge clk) disable iff (!rst) $rose(out_req) |-> !$past(out_ack))
        else report("Output request raised before the previous ack dropped");
    assert property (@(posedge clk) disable iff (!rst) $fell(out_req) |-> $past(out_ack))
        else report("Output request dropped without an ack");
    assert property (@(posedge clk) disable iff (!rst) out_req && $past(out_req)
                     |-> $stable(out_rec))
        else report("Output record changed during the handshake");
    assert property (@(posedge clk) disable iff (!rst) $rose(out_ack) |-> out_rec == exp_rec)
        else report($sformatf("Fail out_rec got %h expected %h", out_rec, exp_rec));

    // Reference model of the next record by decoder priority
    task automatic predict(output llc_pkg::llc_dispatch_t r, output logic ok);
        logic [65:0] w;
        logic        calm;
        logic        dma_pend;
        r        = '0;
        ok       = 1'b1;
        calm     = !status.recall_pending;
        dma_pend = status.dma_read_pending || status.dma_write_pending;
        if (!calm && (status.recall_valid || rsp_q.size() == 0)) begin
            ok = 1'b0;
        end else if (calm && status.rst_stall) begin
            r.kind = llc_pkg::kind_rst_resume;
        end else if (calm && status.flush_stall) begin
            r.kind = llc_pkg::kind_flush_resume;
            r.look = 1'b1;
        end else if (calm && !dma_pend && rst_q.size() > 0) begin
            w         = rst_q.pop_front();
            r.kind    = llc_pkg::kind_rst;
            r.data[0] = w[0];
        end else if (rsp_q.size() > 0) begin
            w                = rsp_q.pop_front();
            r.kind           = llc_pkg::kind_rsp;
            r.look           = 1'b1;
            {r.addr, r.data} = w[63:0];
        end else if (!status.req_stall && (stalled_valid || req_q.size() > 0)) begin
            if (stalled_valid) begin
                w             = stalled;     // Replay ahead of the FIFO
                r.kind        = llc_pkg::kind_stalled_req;
                stalled_valid = 1'b0;
            end else begin
                w      = req_q.pop_front();
                r.kind = llc_pkg::kind_req;
            end
            r.look                 = 1'b1;
            {r.op, r.addr, r.data} = w;
            last_req               = w;
        end else if (status.dma_read_pending) begin
            r.kind = llc_pkg::kind_dma_read_resume;
            r.look = 1'b1;
        end else if (dma_q.size() > 0 && (status.dma_write_pending || !status.req_stall)) begin
            w                = dma_q.pop_front();
            r.kind           = status.dma_write_pending ? llc_pkg::kind_dma_write_resume
                                                        : llc_pkg::kind_dma_req;
            r.look           = 1'b1;
            r.op             = {1'b0, w[64]};
            {r.addr, r.data} = w[63:0];
        end else begin
            ok = 1'b0;
        end
    endtask

    always @(negedge clk) begin
        if (rst && out_req && !out_req_seen) begin
            predict(exp_rec, due);
            assert (due) else report("Record issued when none was due");
        end
        out_req_seen = out_req;
    end

    // Consumer acks only while records are granted
    always begin
        @(negedge clk);
        if (rst && out_req && budget > 0) begin
            rnd = xorshift(rnd);
            repeat (rnd % 4) @(posedge clk);
            @(posedge clk);
            out_ack <= 1'b1;
            @(negedge clk);
            while (out_req) @(negedge clk);
            @(posedge clk);
            out_ack <= 1'b0;
            checks++;
            budget--;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, %0d errors so far", cycles, errors);
            $display("Finished with errors");
            $finish;
        end
    end

    function automatic logic ack_of(input int src);
        case (src)
            0:       return rst_in_ack;
            1:       return rsp_in_ack;
            2:       return req_in_ack;
            default: return dma_in_ack;
        endcase
    endfunction

    task automatic drive(input int src, input logic r, input logic [65:0] w);
        case (src)
            0: begin
                rst_in_req  <= r;
                rst_in_data <= w[0:0];
            end
            1: begin
                rsp_in_req  <= r;
                rsp_in_data <= w[63:0];
            end
            2: begin
                req_in_req  <= r;
                req_in_data <= w;
            end
            default: begin
                dma_in_req  <= r;
                dma_in_data <= w[64:0];
            end
        endcase
    endtask

    task automatic push(input int src, input logic [65:0] w);
        int n;
        @(posedge clk);
        drive(src, 1'b1, w);
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!ack_of(src) && n < 200);
        @(posedge clk);
        drive(src, 1'b0, w);
        if (!ack_of(src)) begin
            report($sformatf("Source %0d never acked its word", src));
            return;
        end
        case (src)
            0:       rst_q.push_back(w);
            1:       rsp_q.push_back(w);
            2:       req_q.push_back(w);
            default: dma_q.push_back(w);
        endcase
        while (ack_of(src)) @(negedge clk);
    endtask

    task automatic load(input int src, input int n);
        logic [65:0] w;
        repeat (n) begin
            rnd = xorshift(rnd);
            w   = {rnd[3:2], rnd ^ 32'h5a5a_0f0f, rnd};
            push(src, w);
        end
    endtask

    // Keep a word on a full port and make sure it is refused
    task automatic hold_off(input int src, input logic [65:0] w);
        @(posedge clk);
        drive(src, 1'b1, w);
        repeat (20) begin
            @(negedge clk);
            assert (!ack_of(src)) else report($sformatf("Full source %0d took a word", src));
        end
    endtask

    task automatic set_status(input llc_pkg::llc_status_t s);
        @(posedge clk);
        status <= s;
    endtask

    task automatic save_pulse();
        @(posedge clk);
        status.save_req <= 1'b1;
        stalled       = last_req;
        stalled_valid = 1'b1;
        @(posedge clk);
        status.save_req <= 1'b0;
    endtask

    task automatic run(input int n);
        budget = budget + n;
        wait (budget == 0);
        repeat (6) @(posedge clk);             // Let the next record reach the port
    endtask

    initial begin
        logic [65:0] w;
        rst           = 1'b0;
        rst_in_req    = 1'b0;
        rst_in_data   = '0;
        rsp_in_req    = 1'b0;
        rsp_in_data   = '0;
        req_in_req    = 1'b0;
        req_in_data   = '0;
        dma_in_req    = 1'b0;
        dma_in_data   = '0;
        status        = st_park;
        out_ack       = 1'b0;
        exp_rec       = '0;
        last_req      = '0;
        stalled       = '0;
        stalled_valid = 1'b0;
        out_req_seen  = 1'b0;
        rnd           = 32'h40b6_fa83;
        errors        = 0;
        checks        = 0;
        budget        = 0;
        cycles        = 0;
        repeat (10) @(posedge clk);
        rst <= 1'b1;

        for (int s = 0; s < 4; s++) load(s, 2); // Fixed priority over loaded FIFOs
        set_status(st_idle);
        run(8);

        set_status(st_park);
        load(1, 2);
        load(2, 1);
        set_status(8'h80);                     // Recall not yet valid
        run(2);
        repeat (10) @(posedge clk);
        set_status(st_idle);
        run(1);
        set_status(8'hc4);                     // Valid recall with DMA read pending
        load(0, 1);                            // Held back by the DMA read, then kept through both stalls
        repeat (10) @(posedge clk);
        set_status(8'h04);
        run(1);
        set_status(st_park);
        run(1);

        set_status(8'h20);
        run(2);
        set_status(8'h10);
        run(2);
        set_status(st_park);
        run(1);
        load(3, 2);
        set_status(8'h02);                     // DMA write pending holds the reset back
        run(2);
        repeat (10) @(posedge clk);
        set_status(st_idle);
        run(1);

        set_status(st_park);
        load(2, 3);
        load(3, 1);
        set_status(st_idle);
        run(1);
        save_pulse();
        set_status(8'h08);
        run(1);
        repeat (20) @(posedge clk);
        set_status(st_idle);
        run(3);

        for (int s = 0; s < 4; s++) begin
            load(s, `LLC_FIFO_DEPTH + 1);
            rnd = xorshift(rnd);
            w   = {rnd[3:2], rnd ^ 32'h5a5a_0f0f, rnd};
            hold_off(s, w);
            fork
                push(s, w);
                run(`LLC_FIFO_DEPTH + 2);
            join
        end

        assert (rst_q.size() + rsp_q.size() + req_q.size() + dma_q.size() == 0 && !stalled_valid)
            else report("Words still queued in the model at the end");
        $display("Records checked %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: llc_front.f
+incdir+include
src/llc_pkg.sv
src/llc_in_fifo.sv
src/llc_input_decoder.sv
src/llc_resume_regs.sv
src/llc_dispatch.sv
src/llc_front.sv
verif/llc_front_tb.sv
